//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] xlen_t;      // register, immediate and alu data
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] inst_word_t; // raw instruction
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // instruction format, picks the immediate layout
    typedef enum logic [2:0] {
        type_r,
        type_i,
        type_s,
        type_b,
        type_u,
        type_j,
        type_n  // unknown opcode
    } inst_type_e;

    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    // recognized only so the core can refuse them
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_system = 7'b1110011;

    // alu funct3, shared by reg and imm forms
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

endpackage

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

    import rv_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // source of alu operand a
    typedef enum logic [1:0] {
        a_rs1,
        a_pc,   // auipc, jal, branch target
        a_zero  // lui
    } a_sel_e;

    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;       // sign-extended
        alu_op_e  alu_op;
        a_sel_e   a_sel;
        logic     b_is_imm;  // operand b from imm instead of rs2
        logic     is_branch; // condition travels in funct3
        logic     is_jal;
        logic     is_jalr;
        logic     writes_rd;
    } ctrl_t;

    // writeback port, one per retired instruction
    typedef struct packed {
        logic     rd_we;
        reg_idx_t rd;
        xlen_t    rd_data;
    } retire_t;

    localparam logic [31:0] reset_pc_default = 32'h8000_0000;

endpackage

//--- logic/rv_decode.sv
`timescale 1ns/1ns

module rv_decode import rv_isa_pkg::*, rv_core_pkg::*; (
    input  inst_word_t inst,
    output ctrl_t      ctrl,
    output funct3_t    funct3
);

    opcode_t    opcode;
    funct7_t    funct7;
    inst_type_e inst_type;
    xlen_t      imm;

    // alu op for reg and imm forms; funct7[5] picks sub or sra
    function automatic alu_op_e alu_decode(input funct3_t f3, input funct7_t f7,
                                           input logic is_reg);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = (is_reg && f7[5]) ? alu_sub : alu_add; // no subi
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = f7[5] ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            op_reg:                               inst_type = type_r;
            op_imm, op_jalr, op_load, op_system:  inst_type = type_i;
            op_store:                             inst_type = type_s;
            op_branch:                            inst_type = type_b;
            op_lui, op_auipc:                     inst_type = type_u;
            op_jal:                               inst_type = type_j;
            default:                              inst_type = type_n;
        endcase
    end

    always_comb begin
        case (inst_type)
            type_i:  imm = {{20{inst[31]}}, inst[31:20]};
            type_s:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            type_b:  imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            type_u:  imm = {inst[31:12], 12'b0};
            type_j:  imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            default: imm = '0; // r-type and unknown carry none
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.rs1       = inst[19:15];
        ctrl.rs2       = inst[24:20];
        ctrl.rd        = inst[11:7];
        ctrl.imm       = imm;
        ctrl.alu_op    = alu_add;
        ctrl.a_sel     = a_rs1;

        case (opcode)
            op_reg: begin
                ctrl.alu_op    = alu_decode(funct3, funct7, 1'b1);
                ctrl.writes_rd = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = alu_decode(funct3, funct7, 1'b0);
                ctrl.b_is_imm  = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            op_lui: begin
                ctrl.a_sel     = a_zero;
                ctrl.b_is_imm  = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            op_auipc: begin
                ctrl.a_sel     = a_pc;
                ctrl.b_is_imm  = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            op_jal: begin
                ctrl.a_sel     = a_pc;     // alu forms pc + imm
                ctrl.b_is_imm  = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            op_jalr: begin
                ctrl.b_is_imm  = 1'b1;     // rs1 + imm
                ctrl.is_jalr   = 1'b1;
                ctrl.writes_rd = 1'b1;
            end
            op_branch: begin
                ctrl.a_sel     = a_pc;
                ctrl.b_is_imm  = 1'b1;
                ctrl.is_branch = 1'b1;
            end
            op_load, op_store, op_system: begin
                ctrl.writes_rd = 1'b0;     // not supported, falls through to pc+4
            end
            default: begin
                ctrl.writes_rd = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ns

module rv_execute import rv_isa_pkg::*, rv_core_pkg::*; (
    input  ctrl_t   ctrl,
    input  funct3_t funct3,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    input  addr_t   pc,
    output xlen_t   alu_result,
    output logic    jump_en,
    output addr_t   jump_target
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [4:0] shamt;
    logic       branch_taken;

    always_comb begin
        case (ctrl.a_sel)
            a_rs1:   op_a = rs1_data;
            a_pc:    op_a = pc;
            default: op_a = '0;
        endcase
    end

    assign op_b  = ctrl.b_is_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0]; // upper bits ignored for shifts

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $signed(op_a) >>> shamt;
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = '0;
        endcase
    end

    // branch compares registers directly, the alu is busy with the target
    always_comb begin
        case (funct3)
            f3_beq:  branch_taken = (rs1_data == rs2_data);
            f3_bne:  branch_taken = (rs1_data != rs2_data);
            f3_blt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: branch_taken = (rs1_data < rs2_data);
            f3_bgeu: branch_taken = (rs1_data >= rs2_data);
            default: branch_taken = 1'b0; // 010 and 011 are reserved
        endcase
    end

    assign jump_en = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && branch_taken);

    // pc + imm for jal and branches, rs1 + imm with bit 0 cleared for jalr
    assign jump_target = ctrl.is_jalr ? {alu_result[31:1], 1'b0} : alu_result;

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile import rv_isa_pkg::*, rv_core_pkg::*; (
    input  logic     clk,
    input  retire_t  retire,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [32];

    // rd_we already excludes x0
    always_ff @(posedge clk) begin
        if (retire.rd_we) begin
            regs[retire.rd] <= retire.rd_data;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/rv_result.sv
`timescale 1ns/1ns

module rv_result import rv_isa_pkg::*, rv_core_pkg::*; #(
    parameter addr_t RESET_PC = reset_pc_default
) (
    input  logic    clk,
    input  logic    reset,
    input  ctrl_t   ctrl,
    input  xlen_t   alu_result,
    input  logic    jump_en,
    input  addr_t   jump_target,
    output addr_t   pc,
    output retire_t retire
);

    addr_t pc_plus4;
    addr_t next_pc;

    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = jump_en ? jump_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        retire.rd    = ctrl.rd;
        retire.rd_we = ctrl.writes_rd && (ctrl.rd != '0) && !reset;
        // link address for jumps
        if (ctrl.is_jal || ctrl.is_jalr) begin
            retire.rd_data = pc_plus4;
        end else begin
            retire.rd_data = alu_result;
        end
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns

module rv_core import rv_isa_pkg::*, rv_core_pkg::*; #(
    parameter addr_t RESET_PC = reset_pc_default
) (
    input  logic       clk,
    input  logic       reset,
    output addr_t      pc,
    input  inst_word_t inst,    // returned for pc in the same cycle
    output retire_t    retire
);

    ctrl_t   ctrl;
    funct3_t funct3;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    xlen_t   alu_result;
    logic    jump_en;
    addr_t   jump_target;

    rv_decode i_decode (
        .inst   (inst),
        .ctrl   (ctrl),
        .funct3 (funct3)
    );

    rv_regfile i_regfile (
        .clk    (clk),
        .retire (retire),   // write back at the edge
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute i_execute (
        .ctrl        (ctrl),
        .funct3      (funct3),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .pc          (pc),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    rv_result #(
        .RESET_PC (RESET_PC)
    ) i_result (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .retire      (retire)
    );

endmodule

//--- tests/rv_core_properties.sv
`timescale 1ns/1ns

module rv_core_properties import rv_isa_pkg::*, rv_core_pkg::*; #(
    parameter addr_t RESET_PC = reset_pc_default
) (
    input logic    clk,
    input logic    reset,
    input addr_t   pc,
    input retire_t retire
);

    // x0 is never a write target
    a_no_x0_write: assert property (@(posedge clk) retire.rd_we |-> retire.rd != '0)
        else $error("register write strobe set for x0");

    a_we_low_in_reset: assert property (@(posedge clk) reset |-> !retire.rd_we)
        else $error("register write strobe set during reset");

    a_pc_after_reset: assert property (@(posedge clk) reset |=> pc == RESET_PC)
        else $error("pc not at reset address after reset");

    // all kept jumps land on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not 4-byte aligned");

endmodule

bind rv_core rv_core_properties #(
    .RESET_PC (RESET_PC)
) i_properties (
    .clk    (clk),
    .reset  (reset),
    .pc     (pc),
    .retire (retire)
);

//--- tests/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb import rv_isa_pkg::*, rv_core_pkg::*; ();

    localparam addr_t      reset_pc       = 32'h8000_0000;
    localparam int         rand_count     = 200;
    localparam int         directed_bound = 180; // reset, directed tests, register init
    localparam int         watchdog_ns    = (rand_count + directed_bound) * 10 + 500;
    localparam inst_word_t nop            = 32'h0000_0013; // addi x0, x0, 0

    logic       clk;
    logic       reset;
    inst_word_t inst;
    addr_t      pc;
    retire_t    retire;

    xlen_t       model_regs [32];
    addr_t       exp_pc;
    logic [31:0] lcg_state    = 32'd83224;
    int          err_count    = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    rv_core #(
        .RESET_PC (reset_pc)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .inst   (inst),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic inst_word_t enc_r(funct3_t f3, logic alt, reg_idx_t rd,
                                         reg_idx_t rs1, reg_idx_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic inst_word_t enc_i(opcode_t opc, funct3_t f3, reg_idx_t rd,
                                         reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_word_t enc_u(opcode_t opc, reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic inst_word_t enc_b(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2,
                                         logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic inst_word_t enc_j(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // alt selects sub or sra
    function automatic xlen_t alu_ref(funct3_t f3, logic alt, xlen_t a, xlen_t b);
        xlen_t res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    function automatic logic branch_ref(funct3_t f3, xlen_t a, xlen_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // expected retire and next pc for one instruction at exp_pc
    function automatic void predict(input inst_word_t w, output retire_t r, output addr_t npc);
        xlen_t a;
        xlen_t b;
        xlen_t imm_i;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        r     = '0;
        r.rd  = w[11:7];
        npc   = exp_pc + 32'd4;
        case (w[6:0])
            op_reg: begin
                r.rd_we   = 1'b1;
                r.rd_data = alu_ref(w[14:12], w[30], a, b);
            end
            op_imm: begin
                r.rd_we   = 1'b1;
                r.rd_data = alu_ref(w[14:12], w[30] && (w[14:12] == 3'd5), a, imm_i);
            end
            op_lui: begin
                r.rd_we   = 1'b1;
                r.rd_data = {w[31:12], 12'b0};
            end
            op_auipc: begin
                r.rd_we   = 1'b1;
                r.rd_data = exp_pc + {w[31:12], 12'b0};
            end
            op_jal: begin
                r.rd_we   = 1'b1;
                r.rd_data = exp_pc + 32'd4;
                npc = exp_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            op_jalr: begin
                r.rd_we   = 1'b1;
                r.rd_data = exp_pc + 32'd4;
                npc       = (a + imm_i) & ~32'd1;
            end
            op_branch: begin
                if (branch_ref(w[14:12], a, b)) begin
                    npc = exp_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: ; // refused or unknown opcodes only advance pc
        endcase
        if (r.rd == 5'd0) begin
            r.rd_we = 1'b0;
        end
    endfunction

    task automatic compare_retire(input retire_t exp, input retire_t act);
        if (exp.rd_we !== act.rd_we ||
            (exp.rd_we && (exp.rd !== act.rd || exp.rd_data !== act.rd_data))) begin
            err_count++;
            $display("Fail retire at pc %h: expected we %h rd %h data %h, got we %h rd %h data %h",
                     exp_pc, exp.rd_we, exp.rd, exp.rd_data, act.rd_we, act.rd, act.rd_data);
        end
    endtask

    task automatic compare_pc(input addr_t exp, input addr_t act);
        if (act !== exp) begin
            err_count++;
            $display("Fail pc: expected %h, got %h", exp, act);
        end
    endtask

    // one instruction per cycle checked at the falling edge
    task automatic exec_inst(input inst_word_t w);
        retire_t exp_ret;
        addr_t   npc;
        @(posedge clk);
        inst <= w;
        @(negedge clk);
        predict(w, exp_ret, npc);
        compare_pc(exp_pc, pc);
        compare_retire(exp_ret, retire);
        if (exp_ret.rd_we) begin
            model_regs[exp_ret.rd] = exp_ret.rd_data;
        end
        exp_pc = npc;
    endtask

    task automatic load_const(input reg_idx_t rd, input xlen_t value);
        xlen_t upper;
        upper = value + 32'h800; // addi sign-extends its immediate
        exec_inst(enc_u(op_lui, rd, upper[31:12]));
        exec_inst(enc_i(op_imm, 3'd0, rd, rd, value[11:0]));
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_reset_sequence();
        int errs;
        errs = err_count;
        @(posedge clk);
        reset <= 1'b1;
        inst  <= enc_i(op_imm, 3'd0, 5'd5, 5'd0, 12'h7ff); // writes x5 unless held off
        @(negedge clk);
        compare_pc(reset_pc, pc);
        compare_retire('0, retire);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        inst  <= nop;
        @(negedge clk);
        compare_pc(reset_pc, pc);
        compare_retire('0, retire);
        exp_pc = reset_pc + 32'd4; // nop at RESET_PC retires here
        exec_inst(nop);
        exec_inst(enc_i(op_imm, 3'd0, 5'd5, 5'd0, 12'h00a));
        exec_inst(enc_i(op_imm, 3'd0, 5'd5, 5'd5, 12'h001));
        exec_inst(nop);
        end_test("reset and sequencing", errs);
    endtask

    task automatic test_reg_alu();
        int      errs;
        funct3_t f3;
        logic    alt;
        errs = err_count;
        load_const(5'd1, 32'h8000_0123);
        exec_inst(enc_i(op_imm, 3'd0, 5'd2, 5'd0, 12'd7));
        load_const(5'd3, next_random());
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? funct3_t'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8); // sub and sra in the last two passes
            exec_inst(enc_r(f3, alt, reg_idx_t'(10 + k), 5'd1, 5'd2));
            exec_inst(enc_r(f3, alt, reg_idx_t'(20 + k), 5'd3, 5'd1));
        end
        end_test("register alu", errs);
    endtask

    task automatic test_imm_upper();
        int errs;
        errs = err_count;
        exec_inst(enc_i(op_imm, f3_add_sub, 5'd4, 5'd1, 12'hfff));
        exec_inst(enc_i(op_imm, f3_xor, 5'd5, 5'd1, 12'h800));
        exec_inst(enc_i(op_imm, f3_slt, 5'd6, 5'd1, 12'hfff));
        exec_inst(enc_i(op_imm, f3_sltu, 5'd7, 5'd2, 12'hfff));
        exec_inst(enc_i(op_imm, f3_and, 5'd8, 5'd3, 12'hff0));
        exec_inst(enc_i(op_imm, f3_or, 5'd9, 5'd2, 12'hf00));
        exec_inst(enc_i(op_imm, f3_sll, 5'd10, 5'd1, 12'h004));
        exec_inst(enc_i(op_imm, f3_srl_sra, 5'd11, 5'd1, 12'h01f));
        exec_inst(enc_i(op_imm, f3_srl_sra, 5'd12, 5'd1, 12'h408)); // srai by 8
        exec_inst(enc_u(op_lui, 5'd13, 20'habcde));
        exec_inst(enc_u(op_auipc, 5'd14, 20'h12345));
        end_test("immediates lui auipc", errs);
    endtask

    task automatic test_x0_refused();
        int errs;
        errs = err_count;
        exec_inst(enc_i(op_imm, 3'd0, 5'd0, 5'd2, 12'd5));
        exec_inst(enc_r(3'd0, 1'b0, 5'd0, 5'd1, 5'd2));
        exec_inst(enc_u(op_lui, 5'd0, 20'hfffff));
        exec_inst(enc_r(3'd0, 1'b0, 5'd15, 5'd0, 5'd0));
        exec_inst(enc_i(op_imm, 3'd6, 5'd16, 5'd0, 12'h123));
        exec_inst(enc_i(op_load, 3'd2, 5'd17, 5'd1, 12'h010));
        exec_inst(enc_i(op_store, 3'd2, 5'd18, 5'd1, 12'h020)); // rd field is imm here
        exec_inst(enc_i(op_system, 3'd0, 5'd0, 5'd0, 12'h000));
        exec_inst(enc_i(op_system, 3'd1, 5'd19, 5'd1, 12'h300));
        exec_inst(enc_i(7'b0001111, 3'd0, 5'd20, 5'd0, 12'h0ff)); // fence is not kept
        end_test("x0 and refused opcodes", errs);
    endtask

    task automatic test_branches_jumps();
        int          errs;
        xlen_t       rnd;
        funct3_t     conds [6];
        logic [12:0] offs;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        errs  = err_count;
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        rnd   = next_random();
        load_const(5'd20, rnd);
        load_const(5'd21, rnd ^ 32'h8000_0000); // signed and unsigned order disagree
        exec_inst(enc_i(op_imm, 3'd0, 5'd22, 5'd20, 12'd0));
        foreach (conds[c]) begin
            for (int p = 0; p < 3; p++) begin
                rnd  = next_random();
                offs = {rnd[12], 1'b1, rnd[10:2], 2'b00}; // never 0 or 4
                rs1  = (p == 2) ? 5'd21 : 5'd20;
                rs2  = (p == 0) ? 5'd22 : ((p == 1) ? 5'd21 : 5'd20);
                exec_inst(enc_b(conds[c], rs1, rs2, offs));
            end
        end
        exec_inst(enc_j(5'd1, 21'h000100));
        exec_inst(enc_j(5'd0, 21'h1ffff8));
        load_const(5'd25, 32'h8000_1000);
        exec_inst(enc_i(op_jalr, 3'd0, 5'd26, 5'd25, 12'h005)); // odd target
        exec_inst(enc_i(op_jalr, 3'd0, 5'd27, 5'd25, 12'hff8));
        end_test("branches and jumps", errs);
    endtask

    task automatic test_random_stream();
        int          errs;
        xlen_t       rnd;
        funct3_t     f3;
        logic        alt;
        logic [11:0] imm;
        errs = err_count;
        for (int k = 1; k < 32; k++) begin
            load_const(reg_idx_t'(k), next_random());
        end
        for (int k = 0; k < rand_count; k++) begin
            rnd = next_random();
            f3  = rnd[2:0];
            alt = rnd[3] && (f3 == 3'd5 || (f3 == 3'd0 && rnd[4])); // sub only for reg form
            if (rnd[4]) begin
                exec_inst(enc_r(f3, alt, rnd[9:5], rnd[14:10], rnd[19:15]));
            end else begin
                imm = rnd[31:20];
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, alt, 5'b0, rnd[24:20]};
                end
                exec_inst(enc_i(op_imm, f3, rnd[9:5], rnd[14:10], imm));
            end
        end
        end_test("random alu stream", errs);
    endtask

    initial begin
        reset  = 1'b1;
        inst   = nop;
        exp_pc = reset_pc;
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        test_reset_sequence();
        test_reg_alu();
        test_imm_upper();
        test_x0_refused();
        test_branches_jumps();
        test_random_stream();
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- flist.f
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_regfile.sv
logic/rv_result.sv
logic/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv
